// File: board_pkg.sv
// Board IO shared types

package board_pkg;

    // Debounced inputs: five buttons and four switches
    parameter int GPIO_W = 9;

    // User LEDs
    parameter int LED_W = 8;

    // PCS status vector width
    parameter int STATUS_W = 16;

    // Buttons and switches, raw or debounced
    typedef struct packed {
        logic       btnu;
        logic       btnl;
        logic       btnd;
        logic       btnr;
        logic       btnc;
        logic [3:0] sw;
    } gpio_t;

    // UART inputs from the USB bridge
    typedef struct packed {
        logic rxd;
        logic cts;
    } uart_in_t;

    // SGMII speed field encoding, 2'b11 unused
    typedef enum logic [1:0] {
        SPEED_10   = 2'b00,
        SPEED_100  = 2'b01,
        SPEED_1000 = 2'b10
    } speed_e;

    // PCS/PMA status vector, bit 15 first
    typedef struct packed {
        logic [1:0] pause;
        logic       remote_fault;
        logic       duplex;
        speed_e     speed;
        logic [1:0] remote_fault_encdg;
        logic       phy_link_status;
        logic       rxnotintable;
        logic       rxdisperr;
        logic       rudi_invalid;
        logic       rudi_i;
        logic       rudi_c;
        logic       link_synchronization;
        logic       link_status;
    } pcs_status_t;

    // Status vector split into bytes for the LED debug view
    typedef struct packed {
        logic [STATUS_W/2-1:0] hi;
        logic [STATUS_W/2-1:0] lo;
    } pcs_bytes_t;

    typedef union packed {
        pcs_status_t fields;
        pcs_bytes_t  bytes;
    } pcs_status_u;

    // One status word per port
    typedef struct packed {
        pcs_status_u sgmii;
        pcs_status_u sfp0;
        pcs_status_u sfp1;
    } pcs_status_set_t;

endpackage

// File: reset_sync.sv
// Core reset stretcher

`timescale 1ns/1ps

module reset_sync #(
    parameter int RESET_STAGES = 4
) (
    input  logic clk,
    input  logic rst,
    output logic rst_out
);

    // Stage chain, all ones while rst is high
    logic [RESET_STAGES-1:0] stage_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '1;
        end else begin
            // Drain with zeros toward the last stage
            stage_q <= stage_q << 1;
        end
    end

    // Core reset follows the oldest stage
    assign rst_out = stage_q[RESET_STAGES-1];

endmodule

// File: debounce_switch.sv
// Button and switch debouncer

`timescale 1ns/1ps

module debounce_switch import board_pkg::*; #(
    parameter int DEBOUNCE_N    = 4,
    parameter int DEBOUNCE_RATE = 125000
) (
    input  logic  clk,
    input  logic  rst,
    input  gpio_t in,
    output gpio_t out
);

    localparam int CNT_W = $clog2(DEBOUNCE_RATE + 1);

    // Sample strobe divider
    logic [CNT_W-1:0] cnt_q;
    logic             strobe;

    // Per-bit sample history, newest sample in bit 0
    logic [DEBOUNCE_N-1:0] hist_q [GPIO_W];

    logic [GPIO_W-1:0] in_bits;
    logic [GPIO_W-1:0] out_q;

    assign in_bits = in;
    assign strobe  = (cnt_q == CNT_W'(DEBOUNCE_RATE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (strobe) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < GPIO_W; i++) begin
                hist_q[i] <= '0;
            end
        end else if (strobe) begin
            for (int i = 0; i < GPIO_W; i++) begin
                hist_q[i] <= (hist_q[i] << 1) | DEBOUNCE_N'(in_bits[i]);
            end
        end
    end

    // Output moves only once the whole history agrees
    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= '0;
        end else begin
            for (int i = 0; i < GPIO_W; i++) begin
                if (&hist_q[i]) begin
                    out_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    out_q[i] <= 1'b0;
                end
            end
        end
    end

    assign out = out_q;

endmodule

// File: signal_sync.sv
// UART input synchronizer

`timescale 1ns/1ps

module signal_sync import board_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic     clk,
    input  uart_in_t in,
    output uart_in_t out
);

    // Metastability hardening chain
    uart_in_t sync_q [SYNC_STAGES];

    always_ff @(posedge clk) begin
        sync_q[0] <= in;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    assign out = sync_q[SYNC_STAGES-1];

endmodule

// File: pcs_status_monitor.sv
// PCS status LED select and speed decode

`timescale 1ns/1ps

module pcs_status_monitor import board_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  pcs_status_set_t status,
    input  logic [3:0]      sw,
    input  logic [LED_W-1:0] led_core,
    output logic [LED_W-1:0] led,
    output logic            speed_is_10_100,
    output logic            speed_is_100
);

    pcs_status_u      sel_word;
    logic [LED_W-1:0] led_next;
    speed_e           sgmii_speed;

    // Port select
    // sw[2] off picks BASE-T, on picks SFP
    // sw[1] picks SFP1 over SFP0
    always_comb begin
        if (!sw[2]) begin
            sel_word = status.sgmii;
        end else if (!sw[1]) begin
            sel_word = status.sfp0;
        end else begin
            sel_word = status.sfp1;
        end
    end

    // sw[3] on shows the status vector, sw[0] picks the high byte
    always_comb begin
        if (!sw[3]) begin
            led_next = led_core;
        end else if (sw[0]) begin
            led_next = sel_word.bytes.hi;
        end else begin
            led_next = sel_word.bytes.lo;
        end
    end

    assign sgmii_speed = status.sgmii.fields.speed;

    always_ff @(posedge clk) begin
        if (rst) begin
            led             <= '0;
            speed_is_10_100 <= 1'b0;
            speed_is_100    <= 1'b0;
        end else begin
            led             <= led_next;
            // Unused code 2'b11 counts as 10/100
            speed_is_10_100 <= (sgmii_speed != SPEED_1000);
            speed_is_100    <= (sgmii_speed == SPEED_100);
        end
    end

endmodule

// File: board_io_top.sv
// Board IO glue top level

`timescale 1ns/1ps

module board_io_top import board_pkg::*; #(
    parameter int RESET_STAGES  = 4,
    parameter int DEBOUNCE_N    = 4,
    parameter int DEBOUNCE_RATE = 125000,
    parameter int SYNC_STAGES   = 2
) (
    // 125 MHz clock and raw reset level
    input  logic             clk,
    input  logic             rst,

    // Board inputs
    input  gpio_t            gpio_raw,
    input  uart_in_t         uart_raw,

    // PCS status words and core LED word
    input  pcs_status_set_t  status,
    input  logic [LED_W-1:0] led_core,

    // Core side outputs
    output logic             rst_core,
    output gpio_t            gpio_clean,
    output uart_in_t         uart_sync,

    // LEDs and PCS speed control
    output logic [LED_W-1:0] led,
    output logic             speed_is_10_100,
    output logic             speed_is_100
);

    reset_sync #(
        .RESET_STAGES(RESET_STAGES)
    ) reset_sync_inst (
        .clk    (clk),
        .rst    (rst),
        .rst_out(rst_core)
    );

    debounce_switch #(
        .DEBOUNCE_N   (DEBOUNCE_N),
        .DEBOUNCE_RATE(DEBOUNCE_RATE)
    ) debounce_switch_inst (
        .clk(clk),
        .rst(rst_core),
        .in (gpio_raw),
        .out(gpio_clean)
    );

    // No reset on the synchronizer chain
    signal_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) signal_sync_inst (
        .clk(clk),
        .in (uart_raw),
        .out(uart_sync)
    );

    // Debug select runs from the raw switches
    pcs_status_monitor pcs_status_monitor_inst (
        .clk            (clk),
        .rst            (rst_core),
        .status         (status),
        .sw             (gpio_raw.sw),
        .led_core       (led_core),
        .led            (led),
        .speed_is_10_100(speed_is_10_100),
        .speed_is_100   (speed_is_100)
    );

endmodule

// File: board_io_sva.sv
// Reset and LED assertions

`timescale 1ns/1ps

module board_io_sva import board_pkg::*; #(
    // Each bound instance checks only the rules its host module can see
    parameter bit RST_CHECKS = 1'b1,
    parameter bit MON_CHECKS = 1'b1
) (
    input logic             clk,
    input logic             rst_in,
    input logic             rst_core,
    input logic [LED_W-1:0] led,
    input logic             speed_is_10_100,
    input logic             speed_is_100
);

    int fail_count = 0;

    if (RST_CHECKS) begin : g_rst
        // Raw reset reaches the core reset at the next edge
        rst_stretch_start: assert property (@(posedge clk) rst_in |=> rst_core)
            else begin
                $error("rst_core not high one cycle after rst");
                fail_count++;
            end
    end

    if (MON_CHECKS) begin : g_mon
        led_dark_in_reset: assert property (@(posedge clk) rst_core |=> (led == '0))
            else begin
                $error("led not cleared one cycle after rst_core");
                fail_count++;
            end

        // 100 Mb/s only ever reported as part of 10/100
        speed_flag_order: assert property (
            @(posedge clk) $rose(speed_is_100) |-> speed_is_10_100)
            else begin
                $error("speed_is_100 rose while speed_is_10_100 low");
                fail_count++;
            end
    end

endmodule

bind reset_sync board_io_sva #(
    .RST_CHECKS(1'b1),
    .MON_CHECKS(1'b0)
) u_sva_rst (
    .clk            (clk),
    .rst_in         (rst),
    .rst_core       (rst_out),
    .led            ('0),
    .speed_is_10_100(1'b0),
    .speed_is_100   (1'b0)
);

bind pcs_status_monitor board_io_sva #(
    .RST_CHECKS(1'b0),
    .MON_CHECKS(1'b1)
) u_sva_mon (
    .clk            (clk),
    .rst_in         (1'b0),
    .rst_core       (rst),
    .led            (led),
    .speed_is_10_100(speed_is_10_100),
    .speed_is_100   (speed_is_100)
);

// File: tb_board_io.sv
// Board IO glue testbench

`timescale 1ns/1ps

module tb_board_io import board_pkg::*;;

    localparam int CLK_PERIOD   = 10;
    localparam int RST_STAGES   = 4;
    localparam int DB_N         = 4;
    localparam int DB_RATE      = 8;
    localparam int SYNC_N       = 2;
    localparam int RESET_CYCLES = 4;
    localparam int RUN_CYCLES   = 2000;
    localparam int SEG_CYCLES   = 250;
    localparam int TAIL_CYCLES  = 8;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + RUN_CYCLES + TAIL_CYCLES) * CLK_PERIOD + 1000;

    logic            clk;
    logic            rst;
    gpio_t           gpio_raw;
    uart_in_t        uart_raw;
    pcs_status_set_t status;
    logic [LED_W-1:0] led_core;

    logic            rst_core;
    gpio_t           gpio_clean;
    uart_in_t        uart_sync;
    logic [LED_W-1:0] led;
    logic            speed_is_10_100;
    logic            speed_is_100;

    // Stimulus state
    integer          seed;
    logic            check_en;
    int              hold_left;
    logic            fast_mode;
    gpio_t           gpio_hold;
    int              pulse_left;
    int              assert_fails;

    // Reference model state
    logic            m_rst_core;
    int              m_rst_cnt;
    int              m_cnt;
    logic [DB_N-1:0] m_hist [GPIO_W];
    logic [GPIO_W-1:0] m_gpio;
    logic [GPIO_W-1:0] raw_bits;
    uart_in_t        uart_hist [$];
    uart_in_t        m_uart;
    logic            m_uart_valid;
    logic [LED_W-1:0] m_led;
    logic [1:0]      m_speed;

    board_io_top #(
        .RESET_STAGES (RST_STAGES),
        .DEBOUNCE_N   (DB_N),
        .DEBOUNCE_RATE(DB_RATE),
        .SYNC_STAGES  (SYNC_N)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .gpio_raw       (gpio_raw),
        .uart_raw       (uart_raw),
        .status         (status),
        .led_core       (led_core),
        .rst_core       (rst_core),
        .gpio_clean     (gpio_clean),
        .uart_sync      (uart_sync),
        .led            (led),
        .speed_is_10_100(speed_is_10_100),
        .speed_is_100   (speed_is_100)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic end_with_failure(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    task automatic check_rst(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            end_with_failure(what);
        end
    endtask

    task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            end_with_failure(what);
        end
    endtask

    task automatic check_uart(input uart_in_t got, input uart_in_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            end_with_failure(what);
        end
    endtask

    task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp,
                             input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            end_with_failure(what);
        end
    endtask

    task automatic check_speed(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            end_with_failure(what);
        end
    endtask

    // LED source from the switch rules, sgmii word in bits 47:32
    function automatic logic [LED_W-1:0] led_choice(input logic [47:0] st,
                                                    input logic [3:0] sw,
                                                    input logic [LED_W-1:0] core);
        logic [15:0] word;
        if (!sw[2]) begin
            word = st[47:32];
        end else if (!sw[1]) begin
            word = st[31:16];
        end else begin
            word = st[15:0];
        end
        if (!sw[3]) begin
            return core;
        end
        return sw[0] ? word[15:8] : word[7:0];
    endfunction

    // {10/100, 100} from the sgmii speed code at bits 11:10
    function automatic logic [1:0] speed_flags(input logic [47:0] st);
        logic [1:0] code;
        code = st[43:42];
        return {code != 2'b10, code == 2'b01};
    endfunction

    task automatic drive_random();
        logic [31:0] r;
        logic [63:0] wide;
        r = $random(seed);
        uart_raw <= r[1:0];
        led_core <= r[15:8];
        wide = {$random(seed), $random(seed)};
        status <= wide[47:0];
        // Alternate bursts of chatter with long steady holds
        if (hold_left == 0) begin
            r = $random(seed);
            fast_mode = r[0];
            hold_left = fast_mode ? 4 + int'(r[4:1]) : 32 + int'(r[10:5]);
            gpio_hold = r[19:11];
        end
        hold_left = hold_left - 1;
        if (fast_mode) begin
            r = $random(seed);
            gpio_raw <= r[GPIO_W-1:0];
        end else begin
            gpio_raw <= gpio_hold;
        end
    endtask

    initial begin
        m_rst_core   = 1'b1;
        m_rst_cnt    = 0;
        m_cnt        = 0;
        m_gpio       = '0;
        m_uart       = '0;
        m_uart_valid = 1'b0;
        m_led        = '0;
        m_speed      = '0;
        for (int i = 0; i < GPIO_W; i++) begin
            m_hist[i] = '0;
        end
    end

    // Model sees the same inputs the DUT samples at this edge
    always @(posedge clk) begin
        raw_bits = gpio_raw;
        // Monitor and debouncer use the core reset from before the edge
        if (m_rst_core) begin
            m_cnt   = 0;
            m_gpio  = '0;
            m_led   = '0;
            m_speed = '0;
            for (int i = 0; i < GPIO_W; i++) begin
                m_hist[i] = '0;
            end
        end else begin
            for (int i = 0; i < GPIO_W; i++) begin
                if (m_hist[i] == '1) begin
                    m_gpio[i] = 1'b1;
                end else if (m_hist[i] == '0) begin
                    m_gpio[i] = 1'b0;
                end
            end
            if (m_cnt == DB_RATE - 1) begin
                m_cnt = 0;
                for (int i = 0; i < GPIO_W; i++) begin
                    m_hist[i] = {m_hist[i][DB_N-2:0], raw_bits[i]};
                end
            end else begin
                m_cnt = m_cnt + 1;
            end
            m_led   = led_choice(status, gpio_raw.sw, led_core);
            m_speed = speed_flags(status);
        end

        uart_hist.push_back(uart_raw);
        if (uart_hist.size() >= SYNC_N) begin
            m_uart       = uart_hist.pop_front();
            m_uart_valid = 1'b1;
        end

        // Reset stretch after the low count
        if (rst) begin
            m_rst_cnt  = 0;
            m_rst_core = 1'b1;
        end else begin
            if (m_rst_cnt < RST_STAGES) begin
                m_rst_cnt = m_rst_cnt + 1;
            end
            m_rst_core = (m_rst_cnt < RST_STAGES);
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            check_rst(rst_core, m_rst_core, "rst_core");
            check_gpio(gpio_clean, gpio_t'(m_gpio), "gpio_clean");
            if (m_uart_valid) begin
                check_uart(uart_sync, m_uart, "uart_sync");
            end
            check_led(led, m_led, "led");
            check_speed({speed_is_10_100, speed_is_100}, m_speed, "speed flags");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: test did not finish within %0d ns", WATCHDOG_NS);
        end_with_failure("timeout");
    end

    initial begin
        seed       = 88;
        rst        = 1'b1;
        gpio_raw   = '0;
        uart_raw   = '0;
        status     = '0;
        led_core   = '0;
        check_en   = 1'b0;
        hold_left  = 0;
        fast_mode  = 1'b0;
        gpio_hold  = '0;
        pulse_left = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        check_en = 1'b1;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            drive_random();
            // Reset pulse of random length at the end of each segment
            if (pulse_left > 0) begin
                pulse_left = pulse_left - 1;
                if (pulse_left == 0) begin
                    rst <= 1'b0;
                end
            end else if (cyc % SEG_CYCLES == SEG_CYCLES - 1) begin
                pulse_left = 1 + ($random(seed) & 7);
                rst <= 1'b1;
            end
        end

        repeat (TAIL_CYCLES) @(posedge clk);
        assert_fails = i_dut.reset_sync_inst.u_sva_rst.fail_count +
                       i_dut.pcs_status_monitor_inst.u_sva_mon.fail_count;
        if (assert_fails != 0) begin
            $display("%0d assertion failures during the run", assert_fails);
            end_with_failure("assertion failures");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: build.f
board_pkg.sv
reset_sync.sv
debounce_switch.sv
signal_sync.sv
pcs_status_monitor.sv
board_io_top.sv
board_io_sva.sv
tb_board_io.sv

// File: Makefile
# Verilator flow for the board IO glue

VERILATOR ?= verilator
TOP       ?= tb_board_io
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
